//--- design/i2c_bit_engine.sv
// I2C bit engine driving SCL and data, sampling ACK and read bits

`timescale 1ns/1ps

`include "i2c_cfg.svh"

module i2c_bit_engine
(
   input  logic      sda,
   input  logic      arst_n,
   i2c_sym_if.engine sym,
   input  logic      data_in,
   output logic      scl,
   output logic      data_low,
   output logic      done,
   output logic [7:0] rdata,
   output logic      nack
);

   localparam int Q  = `I2C_QUARTER_CYCLES;
   localparam int DW = $clog2(Q + 1);

   typedef enum logic [2:0]
   {
      ST_IDLE,
      ST_START,
      ST_STOP,
      ST_TX,
      ST_RX
   } state_t;

   state_t        state;
   logic [DW-1:0] div;
   logic [1:0]    quarter;
   logic [3:0]    bit_cnt;
   logic [7:0]    shreg;
   logic          nack_acc;
   logic          tick;
   logic          last_q;
   logic          take;
   logic          scl_nxt;
   logic          dl_nxt;

   assign tick = (state != ST_IDLE) && (div == DW'(Q - 1));

   // START and STOP end after one bit time, bytes after the ACK bit
   assign last_q = tick && (quarter == 2'd3) &&
                   ((state == ST_START) || (state == ST_STOP) || (bit_cnt == 4'd8));

   // Next symbol is taken straight after the current one without an idle gap
   assign take     = !sym.empty && ((state == ST_IDLE) || last_q);
   assign sym.pop  = take;

   always_ff @(posedge sda or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state    <= ST_IDLE;
         div      <= '0;
         quarter  <= 2'd0;
         bit_cnt  <= 4'd0;
         shreg    <= 8'h00;
         nack_acc <= 1'b0;
         done     <= 1'b0;
         rdata    <= 8'h00;
         nack     <= 1'b0;
      end
      else
      begin
         done <= 1'b0;

         // Sample at the end of the second SCL high quarter
         if (tick && (quarter == 2'd2))
         begin
            if ((state == ST_TX) && (bit_cnt == 4'd8) && data_in)
            begin
               nack_acc <= 1'b1;
            end
            if ((state == ST_RX) && (bit_cnt < 4'd8))
            begin
               shreg <= {shreg[6:0], data_in};
            end
         end

         // Next TX bit moves to the top after the SCL low quarter
         if (tick && (quarter == 2'd3) && (state == ST_TX) && (bit_cnt < 4'd8))
         begin
            shreg <= {shreg[6:0], 1'b0};
         end

         if (last_q)
         begin
            if (state == ST_RX)
            begin
               rdata <= shreg;
            end
            if (state == ST_STOP)
            begin
               done     <= 1'b1;
               nack     <= nack_acc;
               nack_acc <= 1'b0;
            end
         end

         if (take)
         begin
            case (sym.rd_sym.kind)
               i2c_pkg::SYM_START:   state <= ST_START;
               i2c_pkg::SYM_STOP:    state <= ST_STOP;
               i2c_pkg::SYM_TX_BYTE: state <= ST_TX;
               default:              state <= ST_RX;
            endcase
            shreg   <= sym.rd_sym.data;
            div     <= '0;
            quarter <= 2'd0;
            bit_cnt <= 4'd0;
         end
         else if (last_q)
         begin
            state <= ST_IDLE;
         end
         else if (state != ST_IDLE)
         begin
            if (tick)
            begin
               div     <= '0;
               quarter <= quarter + 2'd1;
               if (quarter == 2'd3)
               begin
                  bit_cnt <= bit_cnt + 4'd1;
               end
            end
            else
            begin
               div <= div + 1'b1;
            end
         end
      end
   end

   // Line levels for the current quarter
   // Idle holds the last levels
   always_comb
   begin
      scl_nxt = scl;
      dl_nxt  = data_low;
      case (state)
         ST_START:
         begin
            scl_nxt = (quarter == 2'd1) || (quarter == 2'd2);
            dl_nxt  = (quarter >= 2'd2);
         end
         ST_STOP:
         begin
            scl_nxt = (quarter != 2'd0);
            dl_nxt  = (quarter <= 2'd1);
         end
         ST_TX:
         begin
            scl_nxt = (quarter == 2'd1) || (quarter == 2'd2);
            // ACK bit is released for the target
            dl_nxt  = (bit_cnt < 4'd8) && !shreg[7];
         end
         ST_RX:
         begin
            // Released for all 8 bits and for the master NACK
            scl_nxt = (quarter == 2'd1) || (quarter == 2'd2);
            dl_nxt  = 1'b0;
         end
         default:
         begin
            scl_nxt = scl;
            dl_nxt  = data_low;
         end
      endcase
   end

   // Registered so SCL and data are glitch free on the bus
   always_ff @(posedge sda or negedge arst_n)
   begin
      if (!arst_n)
      begin
         scl      <= 1'b1;
         data_low <= 1'b0;
      end
      else
      begin
         scl      <= scl_nxt;
         data_low <= dl_nxt;
      end
   end

   // Data may only move with SCL high to form START or STOP
   a_data_stable_scl_high: assert property (@(posedge sda) disable iff (!arst_n)
      ($changed(data_low) && $past(scl) && scl) |->
         ($past(state) inside {ST_START, ST_STOP}))
      else $error("data line changed while SCL high");

endmodule

//--- design/i2c_cfg.svh
// FIFO depth and I2C bit timing macros

`ifndef I2C_CFG_SVH
`define I2C_CFG_SVH

// sda clock cycles per quarter of one SCL bit period
// Kept small so that simulation runs quickly
`define I2C_QUARTER_CYCLES 4

// Symbol FIFO entries, enough for the 7 symbols of a register read
`define I2C_FIFO_DEPTH 8

`endif

//--- design/i2c_cmd_seq.sv
// Command sequencer that expands a register command into bus symbols

`timescale 1ns/1ps

`include "i2c_cfg.svh"

module i2c_cmd_seq
(
   input  logic          sda,
   input  logic          arst_n,
   input  logic          cmd_valid,
   input  i2c_pkg::cmd_t cmd,
   input  logic          done,
   output logic          busy,
   i2c_sym_if.seq        sym
);

   i2c_pkg::cmd_t cmd_q;
   logic          pushing;
   logic [2:0]    idx;
   logic [2:0]    last_idx;
   logic          accept;

   assign accept = cmd_valid && !busy;

   // Write ends with STOP at index 4, read at index 6
   assign last_idx = cmd_q.read ? 3'd6 : 3'd4;

   always_ff @(posedge sda)
   begin
      if (accept)
      begin
         cmd_q <= cmd;
      end
   end

   always_ff @(posedge sda or negedge arst_n)
   begin
      if (!arst_n)
      begin
         busy    <= 1'b0;
         pushing <= 1'b0;
         idx     <= 3'd0;
      end
      else if (accept)
      begin
         busy    <= 1'b1;
         pushing <= 1'b1;
         idx     <= 3'd0;
      end
      else
      begin
         if (pushing)
         begin
            if (idx == last_idx)
            begin
               pushing <= 1'b0;
            end
            idx <= idx + 3'd1;
         end
         // Held until the engine reports the end of STOP
         if (done)
         begin
            busy <= 1'b0;
         end
      end
   end

   assign sym.push = pushing;

   always_comb
   begin
      sym.wr_sym.kind = i2c_pkg::SYM_STOP;
      sym.wr_sym.data = 8'h00;
      case (idx)
         3'd0:
         begin
            sym.wr_sym.kind = i2c_pkg::SYM_START;
         end
         3'd1:
         begin
            sym.wr_sym.kind = i2c_pkg::SYM_TX_BYTE;
            sym.wr_sym.data = {cmd_q.dev, 1'b0};
         end
         3'd2:
         begin
            sym.wr_sym.kind = i2c_pkg::SYM_TX_BYTE;
            sym.wr_sym.data = cmd_q.reg_addr;
         end
         3'd3:
         begin
            // Repeated START for a read, data byte for a write
            if (cmd_q.read)
            begin
               sym.wr_sym.kind = i2c_pkg::SYM_START;
            end
            else
            begin
               sym.wr_sym.kind = i2c_pkg::SYM_TX_BYTE;
               sym.wr_sym.data = cmd_q.wdata;
            end
         end
         3'd4:
         begin
            if (cmd_q.read)
            begin
               sym.wr_sym.kind = i2c_pkg::SYM_TX_BYTE;
               sym.wr_sym.data = {cmd_q.dev, 1'b1};
            end
         end
         3'd5:
         begin
            sym.wr_sym.kind = i2c_pkg::SYM_RX_BYTE;
         end
         default:
         begin
            sym.wr_sym.kind = i2c_pkg::SYM_STOP;
         end
      endcase
   end

   // A new command must wait until the previous one has completed
   a_no_cmd_while_busy: assert property (@(posedge sda) disable iff (!arst_n)
      busy |-> !cmd_valid)
      else $error("cmd_valid asserted while busy");

   // The whole command must fit in the FIFO even if the engine pops nothing
   a_cmd_fits_fifo: assert property (@(posedge sda) disable iff (!arst_n)
      sym.push |-> (int'(idx) < `I2C_FIFO_DEPTH))
      else $error("command longer than symbol FIFO");

endmodule

//--- design/i2c_master.sv
// I2C master top level joining sequencer, symbol FIFO and bit engine

`timescale 1ns/1ps

module i2c_master
(
   input  logic       sda,
   input  logic       arst_n,
   input  logic       cmd_valid,
   input  logic       cmd_read,
   input  logic [6:0] cmd_dev,
   input  logic [7:0] cmd_reg,
   input  logic [7:0] cmd_wdata,
   output logic       busy,
   output logic       done,
   output logic [7:0] rdata,
   output logic       nack,
   output logic       scl,
   output logic       data_low,
   input  logic       data_in
);

   i2c_pkg::cmd_t cmd;

   i2c_sym_if sym_bus ();

   always_comb
   begin
      cmd.read     = cmd_read;
      cmd.dev      = cmd_dev;
      cmd.reg_addr = cmd_reg;
      cmd.wdata    = cmd_wdata;
   end

   i2c_cmd_seq i_cmd_seq
   (
      .sda       (sda),
      .arst_n    (arst_n),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .done      (done),
      .busy      (busy),
      .sym       (sym_bus.seq)
   );

   i2c_sym_fifo i_sym_fifo
   (
      .sda    (sda),
      .arst_n (arst_n),
      .q      (sym_bus.fifo)
   );

   i2c_bit_engine i_bit_engine
   (
      .sda      (sda),
      .arst_n   (arst_n),
      .sym      (sym_bus.engine),
      .data_in  (data_in),
      .scl      (scl),
      .data_low (data_low),
      .done     (done),
      .rdata    (rdata),
      .nack     (nack)
   );

endmodule

//--- design/i2c_pkg.sv
// Bus symbol kind, bus symbol and register command types

package i2c_pkg;

   // Bus symbols passed from the sequencer to the bit engine
   typedef enum logic [1:0]
   {
      SYM_START   = 2'd0,
      SYM_STOP    = 2'd1,
      // Send a byte and expect ACK from the target
      SYM_TX_BYTE = 2'd2,
      // Receive a byte and answer with NACK
      SYM_RX_BYTE = 2'd3
   } sym_kind_t;

   // Byte is don't care for START, STOP and RX
   typedef struct packed
   {
      sym_kind_t  kind;
      logic [7:0] data;
   } sym_t;

   // One register access
   typedef struct packed
   {
      logic       read;
      logic [6:0] dev;
      logic [7:0] reg_addr;
      logic [7:0] wdata;
   } cmd_t;

endpackage

//--- design/i2c_sym_fifo.sv
// Synchronous FIFO for bus symbols

`timescale 1ns/1ps

`include "i2c_cfg.svh"

module i2c_sym_fifo
(
   input  logic    sda,
   input  logic    arst_n,
   i2c_sym_if.fifo q
);

   localparam int DEPTH = `I2C_FIFO_DEPTH;
   localparam int AW    = $clog2(DEPTH);
   localparam int CW    = $clog2(DEPTH + 1);

   i2c_pkg::sym_t mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic          do_pop;
   logic          full;

   assign q.empty  = (count == '0);
   assign full     = (count == CW'(DEPTH));
   assign do_pop   = q.pop && !q.empty;
   assign q.rd_sym = mem[rd_ptr];

   always_ff @(posedge sda)
   begin
      if (q.push)
      begin
         mem[wr_ptr] <= q.wr_sym;
      end
   end

   always_ff @(posedge sda or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (q.push)
         begin
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop)
         begin
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({q.push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   a_no_push_full: assert property (@(posedge sda) disable iff (!arst_n)
      q.push |-> !full)
      else $error("push into full symbol FIFO");

   a_no_pop_empty: assert property (@(posedge sda) disable iff (!arst_n)
      q.pop |-> !q.empty)
      else $error("pop from empty symbol FIFO");

endmodule

//--- design/i2c_sym_if.sv
// Bus symbol interface with sequencer, FIFO and bit engine modports

`timescale 1ns/1ps

interface i2c_sym_if;

   // One write strobe per symbol
   logic          push;
   i2c_pkg::sym_t wr_sym;

   // FIFO head is visible while not empty
   logic          pop;
   i2c_pkg::sym_t rd_sym;
   logic          empty;

   modport seq (output push, output wr_sym);

   modport fifo (input push, input wr_sym, input pop, output rd_sym, output empty);

   modport engine (input rd_sym, input empty, output pop);

endinterface

//--- dv/tb_clk_gen.sv
// Testbench clock and reset generator

`timescale 1ns/1ps

module tb_clk_gen
(
   output logic sda,
   output logic arst_n
);

   // 10 ns period
   initial
   begin
      sda = 1'b0;
      forever #5 sda = ~sda;
   end

   // Held for 3 cycles and released away from the rising edge
   initial
   begin
      arst_n = 1'b0;
      repeat (3) @(posedge sda);
      @(negedge sda);
      arst_n = 1'b1;
   end

endmodule

//--- dv/tb_i2c_master.sv
// Testbench top with stimulus, reference model, checker and timeout for the I2C master

`timescale 1ns/1ps

`include "i2c_cfg.svh"

module tb_i2c_master;

   localparam logic [6:0] TGT_ADDR       = 7'h2A;
   localparam int         NUM_CMDS       = 45;
   localparam int         TIMEOUT_CYCLES = NUM_CMDS * 160 * `I2C_QUARTER_CYCLES * 2;

   typedef struct packed
   {
      logic       read;
      logic       nack;
      logic [7:0] rdata;
   } exp_t;

   logic       sda;
   logic       arst_n;
   logic       cmd_valid;
   logic       cmd_read;
   logic [6:0] cmd_dev;
   logic [7:0] cmd_reg;
   logic [7:0] cmd_wdata;
   logic       busy;
   logic       done;
   logic [7:0] rdata;
   logic       nack;
   logic       scl;
   logic       data_low;
   logic       tgt_pull_low;
   logic       bus_data;

   logic [7:0]  mirror [256];
   exp_t        exp_q [$];
   logic [31:0] lcg_state;
   int          errors = 0;
   int          errors_at_start = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;
   int          n_issued = 0;
   int          n_done = 0;
   int          cycles = 0;

   // Wired-AND data line
   assign bus_data = !(data_low || tgt_pull_low);

   tb_clk_gen i_clk_gen
   (
      .sda    (sda),
      .arst_n (arst_n)
   );

   i2c_master i_i2c_master
   (
      .sda       (sda),
      .arst_n    (arst_n),
      .cmd_valid (cmd_valid),
      .cmd_read  (cmd_read),
      .cmd_dev   (cmd_dev),
      .cmd_reg   (cmd_reg),
      .cmd_wdata (cmd_wdata),
      .busy      (busy),
      .done      (done),
      .rdata     (rdata),
      .nack      (nack),
      .scl       (scl),
      .data_low  (data_low),
      .data_in   (bus_data)
   );

   tb_i2c_target #(.DEV_ADDR(TGT_ADDR)) i_target
   (
      .scl       (scl),
      .data_line (bus_data),
      .pull_low  (tgt_pull_low)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Absent device leaves the line released, so a read sees all ones
   function automatic exp_t ref_result(input logic read, input logic [6:0] dev,
                                       input logic [7:0] reg_addr);
      exp_t r;
      r.read = read;
      if (dev != TGT_ADDR)
      begin
         r.nack  = 1'b1;
         r.rdata = 8'hFF;
      end
      else
      begin
         r.nack  = 1'b0;
         r.rdata = read ? mirror[reg_addr] : 8'h00;
      end
      return r;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
      if (got !== expected)
      begin
         $display("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, expected);
         errors = errors + 1;
      end
   endtask

   task automatic end_test(input string name);
      if (errors == errors_at_start)
      begin
         $display("test %s: ok", name);
         tests_passed = tests_passed + 1;
      end
      else
      begin
         $display("test %s: failed with %0d errors", name, errors - errors_at_start);
         tests_failed = tests_failed + 1;
      end
      errors_at_start = errors;
   endtask

   task automatic issue_cmd(input logic read, input logic [6:0] dev,
                            input logic [7:0] reg_addr, input logic [7:0] wdata);
      exp_q.push_back(ref_result(read, dev, reg_addr));
      if (!read && (dev == TGT_ADDR))
      begin
         mirror[reg_addr] = wdata;
      end
      @(posedge sda);
      cmd_valid <= 1'b1;
      cmd_read  <= read;
      cmd_dev   <= dev;
      cmd_reg   <= reg_addr;
      cmd_wdata <= wdata;
      @(posedge sda);
      cmd_valid <= 1'b0;
      n_issued = n_issued + 1;
      wait (n_done == n_issued);
   endtask

   // Completion is checked half a cycle after done rises
   always @(negedge sda)
   begin
      exp_t e;
      if (arst_n && done)
      begin
         if (exp_q.size() == 0)
         begin
            $display("Error: done pulsed at %0t ns with no command outstanding", $time);
            errors = errors + 1;
         end
         else
         begin
            e = exp_q.pop_front();
            check("nack", 32'(nack), 32'(e.nack));
            if (e.read)
            begin
               check("rdata", 32'(rdata), 32'(e.rdata));
            end
         end
         n_done = n_done + 1;
      end
   end

   initial
   begin
      while (cycles < TIMEOUT_CYCLES)
      begin
         @(posedge sda);
         cycles = cycles + 1;
      end
      $display("Timeout: commands did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $finish;
   end

   initial
   begin
      logic       r_read;
      logic [6:0] r_dev;
      logic [7:0] r_reg;
      logic [7:0] r_wdata;
      cmd_valid = 1'b0;
      cmd_read  = 1'b0;
      cmd_dev   = 7'h00;
      cmd_reg   = 8'h00;
      cmd_wdata = 8'h00;
      lcg_state = 32'd98412;
      for (int i = 0; i < 256; i++)
      begin
         mirror[i] = 8'(i) ^ 8'hA5;
      end

      wait (arst_n === 1'b1);
      @(negedge sda);
      check("scl", 32'(scl), 32'd1);
      check("data_low", 32'(data_low), 32'd0);
      check("busy", 32'(busy), 32'd0);
      end_test("reset levels");

      issue_cmd(1'b0, TGT_ADDR, 8'h10, 8'hC3);
      issue_cmd(1'b1, TGT_ADDR, 8'h10, 8'h00);
      end_test("write then read back");

      issue_cmd(1'b1, TGT_ADDR, 8'h7E, 8'h00);
      end_test("read of untouched register");

      issue_cmd(1'b0, 7'h15, 8'h33, 8'h5C);
      issue_cmd(1'b1, TGT_ADDR, 8'h33, 8'h00);
      end_test("write to absent device");

      for (int i = 0; i < 40; i++)
      begin
         lcg_state = lcg_next(lcg_state);
         r_read    = lcg_state[31];
         r_reg     = lcg_state[23:16];
         r_dev     = TGT_ADDR;
         // One command in four goes to another address
         if (lcg_state[29:28] == 2'b00)
         begin
            r_dev = lcg_state[14:8];
            if (r_dev == TGT_ADDR)
            begin
               r_dev = r_dev ^ 7'h01;
            end
         end
         lcg_state = lcg_next(lcg_state);
         r_wdata   = lcg_state[31:24];
         issue_cmd(r_read, r_dev, r_reg, r_wdata);
      end
      end_test("forty random commands");

      $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
               tests_passed, tests_failed, errors);
      if ((errors == 0) && (tests_failed == 0))
      begin
         $display("TB PASSED");
      end
      else
      begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

//--- dv/tb_i2c_target.sv
// Behavioral I2C register target that decodes the bus and answers reads and writes

`timescale 1ns/1ps

module tb_i2c_target
#(
   parameter logic [6:0] DEV_ADDR = 7'h2A
)
(
   input  logic scl,
   input  logic data_line,
   output logic pull_low
);

   typedef enum logic [2:0]
   {
      M_IDLE,
      M_ADDR,
      M_REG,
      M_WDATA,
      M_RDATA
   } mode_t;

   logic [7:0] regs [256];
   mode_t      mode;
   logic [3:0] bit_cnt;
   logic [7:0] shift;
   logic [7:0] ptr;
   logic       is_read;
   logic       prev_scl;
   logic       prev_data;

   // Answer the eighth pulse with ACK or stay silent
   task automatic byte_received();
      case (mode)
         M_ADDR:
         begin
            if (shift[7:1] == DEV_ADDR)
            begin
               is_read  = shift[0];
               pull_low = 1'b1;
            end
            else
            begin
               mode = M_IDLE;
            end
         end
         M_REG:
         begin
            ptr      = shift;
            pull_low = 1'b1;
         end
         M_WDATA:
         begin
            regs[ptr] = shift;
            ptr       = ptr + 8'd1;
            pull_low  = 1'b1;
         end
         default:
         begin
            // Line released for the master ACK or NACK
            pull_low = 1'b0;
         end
      endcase
   endtask

   // Move on to the next byte once the ACK pulse is over
   task automatic ack_done();
      pull_low = 1'b0;
      bit_cnt  = 4'd0;
      if (mode == M_ADDR)
      begin
         mode = is_read ? M_RDATA : M_REG;
      end
      else if (mode == M_REG)
      begin
         mode = M_WDATA;
      end
      if (mode == M_RDATA)
      begin
         shift    = regs[ptr];
         ptr      = ptr + 8'd1;
         pull_low = !shift[7];
      end
   endtask

   initial
   begin
      for (int i = 0; i < 256; i++)
      begin
         regs[i] = 8'(i) ^ 8'hA5;
      end
      mode      = M_IDLE;
      bit_cnt   = 4'd0;
      shift     = 8'h00;
      ptr       = 8'h00;
      is_read   = 1'b0;
      pull_low  = 1'b0;
      prev_scl  = 1'b1;
      prev_data = 1'b1;
      forever
      begin
         @(scl or data_line);
         if (scl && prev_scl && prev_data && !data_line)
         begin
            // START or repeated START
            mode     = M_ADDR;
            bit_cnt  = 4'd0;
            pull_low = 1'b0;
         end
         else if (scl && prev_scl && !prev_data && data_line)
         begin
            mode     = M_IDLE;
            pull_low = 1'b0;
         end
         else if (scl && !prev_scl && (mode != M_IDLE))
         begin
            if (bit_cnt < 4'd8)
            begin
               if (mode != M_RDATA)
               begin
                  shift = {shift[6:0], data_line};
               end
               bit_cnt = bit_cnt + 4'd1;
            end
            else
            begin
               // A master NACK ends the read
               if ((mode == M_RDATA) && data_line)
               begin
                  mode = M_IDLE;
               end
               bit_cnt = 4'd9;
            end
         end
         else if (!scl && prev_scl && (mode != M_IDLE))
         begin
            if (bit_cnt == 4'd8)
            begin
               byte_received();
            end
            else if (bit_cnt == 4'd9)
            begin
               ack_done();
            end
            else if ((mode == M_RDATA) && (bit_cnt != 4'd0))
            begin
               pull_low = !shift[4'd7 - bit_cnt];
            end
         end
         prev_scl  = scl;
         prev_data = data_line;
      end
   end

endmodule

//--- flist.f
+incdir+design
design/i2c_pkg.sv
design/i2c_sym_if.sv
design/i2c_cmd_seq.sv
design/i2c_sym_fifo.sv
design/i2c_bit_engine.sv
design/i2c_master.sv
dv/tb_clk_gen.sv
dv/tb_i2c_target.sv
dv/tb_i2c_master.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the I2C master testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_i2c_master
./obj_dir/Vtb_i2c_master | tee sim.log
if grep -q "TB FAILED" sim.log; then
   exit 1
fi
exit 0
